/* Makefile */
# Verilator build and run for the subcarrier map testbench

VERILATOR ?= verilator
TOP       ?= sc_map_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(wildcard rtl/*.sv sim/*.sv)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the result"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BIN)
	-./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then \
	  echo "simulation reported failure"; exit 1; \
	elif ! grep -q "Test completed successfully" $(LOG); then \
	  echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* compile.f */
rtl/sc_map_pkg.sv
rtl/sc_block_writer.sv
rtl/sc_block_ram.sv
rtl/sc_block_ctrl.sv
rtl/sc_bin_reader.sv
rtl/sc_map_top.sv
sim/sc_map_props.sv
sim/sc_map_tb.sv

/* rtl/sc_bin_reader.sv */
// bin reader: starts symbols, walks bins, maps bins to samples or zero, forms the output stream
`timescale 1ns/10ps

module sc_bin_reader (
  input  logic                                clk_rd,
  input  logic                                rst_n,
  input  logic [sc_map_pkg::BLOC_CNT_W-1:0]   bloc_used,
  input  logic                                dc_enable,
  input  logic                                dout_ready,
  input  sc_map_pkg::sc_word_u                rd_word,
  input  logic [sc_map_pkg::EXP_W-1:0]        rd_exp,
  input  logic [sc_map_pkg::SYM_W-1:0]        rd_symbol,
  output logic [sc_map_pkg::WORD_ADDR_W-1:0]  rd_addr,
  output logic [sc_map_pkg::BLOC_ADDR_W-1:0]  rd_block,
  output logic                                block_release,
  output logic                                dout_valid,
  output logic                                dout_sop,
  output logic                                dout_eop,
  output logic [sc_map_pkg::SAMPLE_W-1:0]     dout_real,
  output logic [sc_map_pkg::SAMPLE_W-1:0]     dout_imag,
  output logic [sc_map_pkg::EXP_W-1:0]        dout_exp,
  output logic [sc_map_pkg::SYM_W-1:0]        dout_symbol,
  output logic [sc_map_pkg::BIN_W-1:0]        dout_index
);

  logic                                active;     // issuing bins
  logic [sc_map_pkg::BIN_W-1:0]        bin_cnt;    // bin being issued
  logic [sc_map_pkg::WORD_ADDR_W-1:0]  rd_base;    // first word of rd_block
  logic                                last_bin;
  logic                                blk_avail;  // a block beyond the one in flight
  logic                                start;
  logic [sc_map_pkg::BIN_W-1:0]        sample;     // sample number within block
  logic                                zero;       // bin carries no subcarrier

  // stage 1, alongside the RAM read
  logic                                v1;
  logic                                sop1;
  logic                                eop1;
  logic                                zero1;
  logic [sc_map_pkg::LANE_W-1:0]       lane1;
  logic [sc_map_pkg::BIN_W-1:0]        idx1;

  assign last_bin      = active & (bin_cnt == sc_map_pkg::BIN_LAST);
  // current block still counted in bloc_used until its release lands
  assign blk_avail     = bloc_used > {{(sc_map_pkg::BLOC_CNT_W - 1){1'b0}}, active};
  assign start         = (~active | last_bin) & blk_avail & dout_ready;
  assign block_release = last_bin;

  // swapped order: upper half from DC up, lower half in the top bins
  always_comb begin
    sample = '0;
    zero   = 1'b1;
    if (bin_cnt >= sc_map_pkg::BIN_UPPER) begin
      sample = bin_cnt - sc_map_pkg::BIN_UPPER;          // samples 0..HALF_SC-1
      zero   = 1'b0;
    end else if (dc_enable && bin_cnt < sc_map_pkg::BIN_HALF) begin
      sample = bin_cnt + sc_map_pkg::BIN_HALF;           // DC bin in use
      zero   = 1'b0;
    end else if (!dc_enable && bin_cnt != '0 && bin_cnt <= sc_map_pkg::BIN_HALF) begin
      sample = bin_cnt + sc_map_pkg::BIN_HALF - 1'b1;    // skip DC, shift up one
      zero   = 1'b0;
    end
  end

  // word part of the sample number, lane part travels down the pipe
  assign rd_addr = rd_base
                 + {{sc_map_pkg::LANE_W{1'b0}}, sample[sc_map_pkg::BIN_W-1:sc_map_pkg::LANE_W]};

  always_ff @(posedge clk_rd or negedge rst_n) begin
    if (!rst_n) begin
      active   <= 1'b0;
      bin_cnt  <= '0;
      rd_block <= '0;
      rd_base  <= '0;
    end else begin
      if (start) begin
        active  <= 1'b1;
        bin_cnt <= '0;                                   // gapless into next symbol
      end else if (last_bin) begin
        active  <= 1'b0;
      end else if (active) begin
        bin_cnt <= bin_cnt + 1'b1;
      end
      if (last_bin) begin                                // step to next slot
        if (rd_block == sc_map_pkg::BLOC_LAST) begin
          rd_block <= '0;
          rd_base  <= '0;
        end else begin
          rd_block <= rd_block + 1'b1;
          rd_base  <= rd_base + sc_map_pkg::WORD_STEP;
        end
      end
    end
  end

  // framing flags, two stages to match the RAM read plus output register
  always_ff @(posedge clk_rd or negedge rst_n) begin
    if (!rst_n) begin
      v1         <= 1'b0;
      sop1       <= 1'b0;
      eop1       <= 1'b0;
      dout_valid <= 1'b0;
      dout_sop   <= 1'b0;
      dout_eop   <= 1'b0;
    end else begin
      v1         <= active;
      sop1       <= active & (bin_cnt == '0);
      eop1       <= last_bin;
      dout_valid <= v1;
      dout_sop   <= sop1;
      dout_eop   <= eop1;
    end
  end

  // payload path
  always_ff @(posedge clk_rd) begin
    zero1       <= zero;
    lane1       <= sample[sc_map_pkg::LANE_W-1:0];
    idx1        <= bin_cnt;
    dout_real   <= zero1 ? '0 : rd_word.iq[0][lane1];   // force zero or pick lane
    dout_imag   <= zero1 ? '0 : rd_word.iq[1][lane1];
    dout_exp    <= rd_exp;                              // same block as this bin
    dout_symbol <= rd_symbol;
    dout_index  <= idx1;
  end

endmodule

/* rtl/sc_block_ctrl.sv */
// block occupancy control: counts held blocks, full and empty flags, credit return
`timescale 1ns/10ps

module sc_block_ctrl (
  input  logic                               clk_rd,
  input  logic                               rst_n,
  input  logic                               block_done,     // writer finished a block
  input  logic                               block_release,  // reader issued last bin
  output logic [sc_map_pkg::BLOC_CNT_W-1:0]  bloc_used,
  output logic                               bloc_full,
  output logic                               bloc_empty,
  output logic                               din_credit      // one credit per release
);

  // done and release in the same cycle cancel out
  always_ff @(posedge clk_rd or negedge rst_n) begin
    if (!rst_n) begin
      bloc_used <= '0;
    end else begin
      case ({block_done, block_release})
        2'b10:   bloc_used <= bloc_used + 1'b1;
        2'b01:   bloc_used <= bloc_used - 1'b1;
        default: bloc_used <= bloc_used;
      endcase
    end
  end

  always_ff @(posedge clk_rd or negedge rst_n) begin
    if (!rst_n) begin
      din_credit <= 1'b0;
    end else begin
      din_credit <= block_release;   // slot is free again
    end
  end

  assign bloc_full  = (bloc_used == sc_map_pkg::BLOC_FULL);
  assign bloc_empty = (bloc_used == '0);

endmodule

/* rtl/sc_block_ram.sv */
// block buffer: sample word memory plus per-block exponent and symbol store, registered reads
`timescale 1ns/10ps

module sc_block_ram (
  input  logic                                clk_rd,
  input  logic                                wr_en,
  input  logic [sc_map_pkg::WORD_ADDR_W-1:0]  wr_addr,
  input  sc_map_pkg::sc_word_u                wr_word,
  input  logic                                meta_wr,
  input  logic [sc_map_pkg::BLOC_ADDR_W-1:0]  meta_addr,
  input  logic [sc_map_pkg::EXP_W-1:0]        din_exp,
  input  logic [sc_map_pkg::SYM_W-1:0]        din_symbol,
  input  logic [sc_map_pkg::WORD_ADDR_W-1:0]  rd_addr,
  input  logic [sc_map_pkg::BLOC_ADDR_W-1:0]  rd_block,
  output sc_map_pkg::sc_word_u                rd_word,     // 1 cycle after rd_addr
  output logic [sc_map_pkg::EXP_W-1:0]        rd_exp,      // 1 cycle after rd_block
  output logic [sc_map_pkg::SYM_W-1:0]        rd_symbol
);

  sc_map_pkg::sc_word_u         mem     [sc_map_pkg::BLOCK_QTY*sc_map_pkg::WORDS_PER_BLOCK];
  logic [sc_map_pkg::EXP_W-1:0] exp_mem [sc_map_pkg::BLOCK_QTY];
  logic [sc_map_pkg::SYM_W-1:0] sym_mem [sc_map_pkg::BLOCK_QTY];

  always_ff @(posedge clk_rd) begin
    if (wr_en) mem[wr_addr] <= wr_word;     // writer and reader never share a slot
    if (meta_wr) begin
      exp_mem[meta_addr] <= din_exp;
      sym_mem[meta_addr] <= din_symbol;
    end
    rd_word   <= mem[rd_addr];
    rd_exp    <= exp_mem[rd_block];
    rd_symbol <= sym_mem[rd_block];
  end

endmodule

/* rtl/sc_block_writer.sv */
// block writer: counts input words into buffer slots, captures metadata, flags finished blocks
`timescale 1ns/10ps

module sc_block_writer (
  input  logic                                clk_rd,
  input  logic                                rst_n,
  input  logic                                din_valid,
  input  logic                                din_sop,
  input  sc_map_pkg::sc_word_u                din_word,
  output logic                                wr_en,       // buffer write strobe
  output logic [sc_map_pkg::WORD_ADDR_W-1:0]  wr_addr,     // slot base + word
  output sc_map_pkg::sc_word_u                wr_word,
  output logic                                meta_wr,     // exp/symbol capture
  output logic [sc_map_pkg::BLOC_ADDR_W-1:0]  meta_addr,
  output logic                                block_done   // one cycle, after last word
);

  logic [sc_map_pkg::WCNT_W-1:0]       word_cnt;   // next word in block
  logic [sc_map_pkg::WCNT_W-1:0]       cur_word;   // word taken this cycle
  logic                                in_blk;     // sop seen, block open
  logic [sc_map_pkg::BLOC_ADDR_W-1:0]  wr_blk;     // slot being filled
  logic [sc_map_pkg::WORD_ADDR_W-1:0]  wr_base;    // first word of that slot
  logic                                last_word;

  assign cur_word  = din_sop ? '0 : word_cnt;               // sop restarts at word 0
  assign wr_en     = din_valid & (din_sop | in_blk);        // stray words outside a block dropped
  assign wr_addr   = wr_base + {{(sc_map_pkg::WORD_ADDR_W - sc_map_pkg::WCNT_W){1'b0}}, cur_word};
  assign wr_word   = din_word;
  assign meta_wr   = din_valid & din_sop;                   // restart overwrites same slot
  assign meta_addr = wr_blk;
  assign last_word = wr_en & (cur_word == sc_map_pkg::WORD_LAST);

  always_ff @(posedge clk_rd or negedge rst_n) begin
    if (!rst_n) begin
      word_cnt   <= '0;
      in_blk     <= 1'b0;
      wr_blk     <= '0;
      wr_base    <= '0;
      block_done <= 1'b0;
    end else begin
      block_done <= last_word;                              // write lands on this same edge
      if (last_word) begin
        word_cnt <= '0;
        in_blk   <= 1'b0;                                   // wait for next sop
        if (wr_blk == sc_map_pkg::BLOC_LAST) begin          // wrap slot ring
          wr_blk  <= '0;
          wr_base <= '0;
        end else begin
          wr_blk  <= wr_blk + 1'b1;
          wr_base <= wr_base + sc_map_pkg::WORD_STEP;
        end
      end else if (wr_en) begin
        word_cnt <= cur_word + 1'b1;
        in_blk   <= 1'b1;
      end
    end
  end

endmodule

/* rtl/sc_map_pkg.sv */
// subcarrier map package: block and symbol sizes, field widths, stored sample word
package sc_map_pkg;

  localparam int FFT_SIZE        = 64;               // bins per output symbol
  localparam int SC_NUM          = 48;               // subcarriers per block
  localparam int HALF_SC         = SC_NUM / 2;       // upper/lower half size
  localparam int LANES           = 4;                // samples per input word
  localparam int WORDS_PER_BLOCK = SC_NUM / LANES;   // input words per block
  localparam int BLOCK_QTY       = 4;                // buffer depth in blocks, also initial credit

  localparam int BLOC_ADDR_W     = 2;                // block pointer width
  localparam int BLOC_CNT_W      = 3;                // occupancy 0..BLOCK_QTY
  localparam int WORD_ADDR_W     = 6;                // buffer word address
  localparam int LANE_W          = 2;                // lane select
  localparam int BIN_W           = 6;                // bin index
  localparam int SAMPLE_W        = 8;                // real or imag part
  localparam int EXP_W           = 6;                // block exponent
  localparam int SYM_W           = 4;                // symbol index
  localparam int READ_LATENCY    = 2;                // bin issue to dout
  localparam int WCNT_W          = $clog2(WORDS_PER_BLOCK); // word-in-block counter

  // sized constants so compares and adds stay width clean
  localparam logic [WCNT_W-1:0]      WORD_LAST  = WCNT_W'(WORDS_PER_BLOCK - 1);
  localparam logic [WORD_ADDR_W-1:0] WORD_STEP  = WORD_ADDR_W'(WORDS_PER_BLOCK);
  localparam logic [BLOC_ADDR_W-1:0] BLOC_LAST  = BLOC_ADDR_W'(BLOCK_QTY - 1);
  localparam logic [BLOC_CNT_W-1:0]  BLOC_FULL  = BLOC_CNT_W'(BLOCK_QTY);
  localparam logic [BIN_W-1:0]       BIN_LAST   = BIN_W'(FFT_SIZE - 1);
  localparam logic [BIN_W-1:0]       BIN_HALF   = BIN_W'(HALF_SC);
  localparam logic [BIN_W-1:0]       BIN_UPPER  = BIN_W'(FFT_SIZE - HALF_SC); // lower half lands here

  // one stored word, written raw and read per lane
  // iq[0] holds the real bytes, iq[1] the imaginary bytes; lane n is byte n of each
  typedef union packed {
    logic [2*LANES*SAMPLE_W-1:0]          raw; // as written by the source
    logic [1:0][LANES-1:0][SAMPLE_W-1:0]  iq;  // {imag lanes, real lanes}
  } sc_word_u;

endpackage

/* rtl/sc_map_top.sv */
// subcarrier map top: block writer, block buffer, occupancy control and bin reader
`timescale 1ns/10ps

module sc_map_top (
  input  logic                                 clk_rd,      // single clock
  input  logic                                 rst_n,       // async, active low
  input  logic                                 din_valid,   // input word valid
  input  logic                                 din_sop,     // first word of a block
  input  sc_map_pkg::sc_word_u                 din_word,    // four samples
  input  logic [sc_map_pkg::EXP_W-1:0]         din_exp,     // taken at sop
  input  logic [sc_map_pkg::SYM_W-1:0]         din_symbol,  // taken at sop
  input  logic                                 dc_enable,   // static while running
  input  logic                                 dout_ready,  // sampled at symbol start
  output logic                                 din_credit,  // one block credit back
  output logic                                 dout_valid,
  output logic                                 dout_sop,
  output logic                                 dout_eop,
  output logic [sc_map_pkg::SAMPLE_W-1:0]      dout_real,
  output logic [sc_map_pkg::SAMPLE_W-1:0]      dout_imag,
  output logic [sc_map_pkg::EXP_W-1:0]         dout_exp,
  output logic [sc_map_pkg::SYM_W-1:0]         dout_symbol,
  output logic [sc_map_pkg::BIN_W-1:0]         dout_index,  // bin number
  output logic [sc_map_pkg::BLOC_CNT_W-1:0]    bloc_used,   // blocks held
  output logic                                 bloc_full,
  output logic                                 bloc_empty
);

  logic                                wr_en;      // buffer write port
  logic [sc_map_pkg::WORD_ADDR_W-1:0]  wr_addr;
  sc_map_pkg::sc_word_u                wr_word;
  logic                                meta_wr;    // metadata write
  logic [sc_map_pkg::BLOC_ADDR_W-1:0]  meta_addr;
  logic                                block_done;
  logic                                block_release;
  logic [sc_map_pkg::WORD_ADDR_W-1:0]  rd_addr;    // buffer read port
  logic [sc_map_pkg::BLOC_ADDR_W-1:0]  rd_block;
  sc_map_pkg::sc_word_u                rd_word;
  logic [sc_map_pkg::EXP_W-1:0]        rd_exp;
  logic [sc_map_pkg::SYM_W-1:0]        rd_symbol;

  sc_block_writer i_writer (
    .clk_rd, .rst_n, .din_valid, .din_sop, .din_word,
    .wr_en, .wr_addr, .wr_word, .meta_wr, .meta_addr, .block_done
  );

  sc_block_ram i_ram (
    .clk_rd, .wr_en, .wr_addr, .wr_word, .meta_wr, .meta_addr, .din_exp, .din_symbol,
    .rd_addr, .rd_block, .rd_word, .rd_exp, .rd_symbol
  );

  sc_block_ctrl i_ctrl (
    .clk_rd, .rst_n, .block_done, .block_release,
    .bloc_used, .bloc_full, .bloc_empty, .din_credit
  );

  sc_bin_reader i_reader (
    .clk_rd, .rst_n, .bloc_used, .dc_enable, .dout_ready, .rd_word, .rd_exp, .rd_symbol,
    .rd_addr, .rd_block, .block_release, .dout_valid, .dout_sop, .dout_eop,
    .dout_real, .dout_imag, .dout_exp, .dout_symbol, .dout_index
  );

endmodule

/* sim/sc_map_props.sv */
// subcarrier map properties: output symbol framing and block occupancy limits
`timescale 1ns/10ps

module sc_map_props (
  input logic                               clk_rd,
  input logic                               rst_n,
  input logic                               dout_valid,
  input logic                               dout_sop,
  input logic                               dout_eop,
  input logic [sc_map_pkg::BLOC_CNT_W-1:0]  bloc_used,
  input logic                               din_credit,
  input logic                               block_release  // reader issued last bin
);

  logic [sc_map_pkg::BIN_W-1:0] run_len;  // bins seen so far in this symbol

  always_ff @(posedge clk_rd or negedge rst_n) begin
    if (!rst_n) begin
      run_len <= '0;
    end else if (dout_valid) begin
      run_len <= dout_eop ? '0 : run_len + 1'b1;
    end
  end

  a_sop_valid: assert property (@(posedge clk_rd) disable iff (!rst_n)
    dout_sop |-> dout_valid && run_len == '0) else $error("sop outside a symbol start");
  a_eop_len: assert property (@(posedge clk_rd) disable iff (!rst_n)
    dout_eop |-> dout_valid && run_len == sc_map_pkg::BIN_LAST) else $error("eop at wrong bin");
  a_run_start: assert property (@(posedge clk_rd) disable iff (!rst_n)
    $rose(dout_valid) |-> dout_sop) else $error("valid run without sop");
  a_no_gap: assert property (@(posedge clk_rd) disable iff (!rst_n)
    dout_valid && !dout_eop |=> dout_valid && !dout_sop) else $error("gap or sop mid symbol");
  a_after_eop: assert property (@(posedge clk_rd) disable iff (!rst_n)
    dout_eop |=> !dout_valid || dout_sop) else $error("valid continues past eop");
  a_used_max: assert property (@(posedge clk_rd) disable iff (!rst_n)
    bloc_used <= sc_map_pkg::BLOC_FULL) else $error("occupancy above buffer depth");
  // credits only ever follow a release of a held block
  a_credit: assert property (@(posedge clk_rd) disable iff (!rst_n)
    din_credit |-> $past(block_release) && $past(bloc_used) != '0)
    else $error("credit without a released block");

endmodule

/* sim/sc_map_tb.sv */
// subcarrier map testbench: credit-gated random source, bin mapping model, output checks
`timescale 1ns/10ps

module sc_map_tb;

  localparam int N_MULTI     = 6;                       // blocks in the metadata test
  localparam int N_STREAM    = 40;                      // blocks in the long random stream
  localparam int TEST_BLOCKS = 1 + 1 + N_MULTI + sc_map_pkg::BLOCK_QTY + 1 + N_STREAM;
  localparam int CYCLE_LIMIT = 2 * TEST_BLOCKS
                             * (sc_map_pkg::FFT_SIZE + sc_map_pkg::WORDS_PER_BLOCK + 8);

  logic                                clk_rd;
  logic                                rst_n;
  logic                                din_valid;
  logic                                din_sop;
  sc_map_pkg::sc_word_u                din_word;
  logic [sc_map_pkg::EXP_W-1:0]        din_exp;
  logic [sc_map_pkg::SYM_W-1:0]        din_symbol;
  logic                                dc_enable;
  logic                                dout_ready;
  logic                                din_credit;
  logic                                dout_valid;
  logic                                dout_sop;
  logic                                dout_eop;
  logic [sc_map_pkg::SAMPLE_W-1:0]     dout_real;
  logic [sc_map_pkg::SAMPLE_W-1:0]     dout_imag;
  logic [sc_map_pkg::EXP_W-1:0]        dout_exp;
  logic [sc_map_pkg::SYM_W-1:0]        dout_symbol;
  logic [sc_map_pkg::BIN_W-1:0]        dout_index;
  logic [sc_map_pkg::BLOC_CNT_W-1:0]   bloc_used;
  logic                                bloc_full;
  logic                                bloc_empty;

  // expected stream, appended by the source and only read by the checker
  logic [sc_map_pkg::SAMPLE_W-1:0]     exp_real_q [$];  // FFT_SIZE bins per block
  logic [sc_map_pkg::SAMPLE_W-1:0]     exp_imag_q [$];
  logic [sc_map_pkg::EXP_W-1:0]        exp_exp_q  [$];  // one entry per block
  logic [sc_map_pkg::SYM_W-1:0]        exp_sym_q  [$];

  int  bin_idx      = 0;   // next expected bin over the whole run
  int  bin_pos      = 0;   // bin within current symbol
  int  out_cnt      = 0;
  int  credit_total = 0;   // din_credit pulses seen
  int  spent        = 0;   // credits used by the source
  int  chk_errs     = 0;   // output checker
  int  seq_errs     = 0;   // test sequence checks
  int  err_mark     = 0;
  int  test_num     = 0;
  int  tests_bad    = 0;
  int  cycle_cnt    = 0;
  bit  stream_done  = 1'b0;

  sc_map_top i_dut (.*);

  bind sc_map_top sc_map_props i_props (
    .clk_rd(clk_rd), .rst_n(rst_n), .dout_valid(dout_valid), .dout_sop(dout_sop),
    .dout_eop(dout_eop), .bloc_used(bloc_used), .din_credit(din_credit),
    .block_release(block_release)
  );

  always #4 clk_rd = ~clk_rd;  // 8 ns period

  // swapped placement: sample number for a bin, -1 for a zero bin
  function automatic int map_bin(input int bin, input logic dc);
    if (bin >= sc_map_pkg::FFT_SIZE - sc_map_pkg::HALF_SC)
      return bin - (sc_map_pkg::FFT_SIZE - sc_map_pkg::HALF_SC);  // lower half at the top
    if (dc && bin < sc_map_pkg::HALF_SC)
      return bin + sc_map_pkg::HALF_SC;                          // upper half from DC
    if (!dc && bin >= 1 && bin <= sc_map_pkg::HALF_SC)
      return bin - 1 + sc_map_pkg::HALF_SC;                      // DC empty, one bin up
    return -1;
  endfunction

  task automatic idle_cycle();
    @(posedge clk_rd);
    #1;
    din_valid = 1'b0;
    din_sop   = 1'b0;
  endtask

  task automatic drive_word(input logic [2*sc_map_pkg::LANES*sc_map_pkg::SAMPLE_W-1:0] w,
                            input logic sop, input logic [sc_map_pkg::EXP_W-1:0] e,
                            input logic [sc_map_pkg::SYM_W-1:0] s);
    @(posedge clk_rd);
    #1;
    din_valid    = 1'b1;
    din_sop      = sop;
    din_word.raw = w;
    din_exp      = e;   // only taken at sop
    din_symbol   = s;
  endtask

  task automatic random_gap(input int pct);
    while (int'($urandom_range(99)) < pct) idle_cycle();
  endtask

  // one block under the credit rule, optionally preceded by an abandoned partial block
  task automatic send_block(input int gap_pct, input int partial);
    logic [2*sc_map_pkg::LANES*sc_map_pkg::SAMPLE_W-1:0] words [sc_map_pkg::WORDS_PER_BLOCK];
    logic [31:0]                   r;
    logic [sc_map_pkg::EXP_W-1:0]  e;
    logic [sc_map_pkg::SYM_W-1:0]  s;
    int                            i;
    int                            smp;
    while (sc_map_pkg::BLOCK_QTY + credit_total - spent == 0) idle_cycle();  // no credit
    spent++;
    for (i = 0; i < partial; i++) begin
      r = $urandom;
      drive_word({$urandom, $urandom}, i == 0, r[sc_map_pkg::EXP_W-1:0],
                 r[sc_map_pkg::EXP_W +: sc_map_pkg::SYM_W]);
      random_gap(gap_pct);
    end
    r = $urandom;
    e = r[sc_map_pkg::EXP_W-1:0];
    s = r[sc_map_pkg::EXP_W +: sc_map_pkg::SYM_W];
    for (i = 0; i < sc_map_pkg::WORDS_PER_BLOCK; i++) begin
      words[i] = {$urandom, $urandom};
      drive_word(words[i], i == 0, e, s);                 // sop restarts any partial block
      if (i < sc_map_pkg::WORDS_PER_BLOCK - 1) random_gap(gap_pct);
    end
    idle_cycle();
    for (i = 0; i < sc_map_pkg::FFT_SIZE; i++) begin
      smp = map_bin(i, dc_enable);
      if (smp < 0) begin
        exp_real_q.push_back('0);
        exp_imag_q.push_back('0);
      end else begin                                       // lane n is byte n of each half
        exp_real_q.push_back(words[smp / sc_map_pkg::LANES]
          [sc_map_pkg::SAMPLE_W * (smp % sc_map_pkg::LANES) +: sc_map_pkg::SAMPLE_W]);
        exp_imag_q.push_back(words[smp / sc_map_pkg::LANES]
          [sc_map_pkg::LANES * sc_map_pkg::SAMPLE_W
           + sc_map_pkg::SAMPLE_W * (smp % sc_map_pkg::LANES) +: sc_map_pkg::SAMPLE_W]);
      end
    end
    exp_exp_q.push_back(e);
    exp_sym_q.push_back(s);
  endtask

  task automatic wait_drain();
    idle_cycle();
    while (bin_idx != exp_real_q.size() || dout_valid) idle_cycle();
  endtask

  task automatic begin_test();
    test_num++;
    err_mark = chk_errs + seq_errs;
  endtask

  task automatic report_test(input string name);
    int n;
    n = chk_errs + seq_errs - err_mark;
    if (n == 0) begin
      $display("test %0d %s: ok", test_num, name);
    end else begin
      $display("test %0d %s: %0d errors", test_num, name, n);
      tests_bad++;
    end
  endtask

  // output checker and credit counter, sampled mid-cycle
  always @(negedge clk_rd) begin
    if (rst_n && din_credit) credit_total++;
    if (rst_n && dout_valid) begin
      out_cnt++;
      assert (bin_idx < exp_real_q.size()) else begin
        $display("output bin appeared with no block left in the model");
        chk_errs++;
      end
      assert (dout_sop == (bin_pos == 0)) else begin
        $display("Error: dout_sop got %h expected %h", dout_sop, bin_pos == 0);
        chk_errs++;
      end
      assert (dout_eop == (bin_pos == sc_map_pkg::FFT_SIZE - 1)) else begin
        $display("Error: dout_eop got %h expected %h", dout_eop,
                 bin_pos == sc_map_pkg::FFT_SIZE - 1);
        chk_errs++;
      end
      assert (int'(dout_index) == bin_pos) else begin
        $display("Error: dout_index got %h expected %h", dout_index, bin_pos);
        chk_errs++;
      end
      if (bin_idx < exp_real_q.size()) begin
        assert (dout_real == exp_real_q[bin_idx]) else begin
          $display("Error: dout_real bin %h got %h expected %h", bin_pos, dout_real,
                   exp_real_q[bin_idx]);
          chk_errs++;
        end
        assert (dout_imag == exp_imag_q[bin_idx]) else begin
          $display("Error: dout_imag bin %h got %h expected %h", bin_pos, dout_imag,
                   exp_imag_q[bin_idx]);
          chk_errs++;
        end
        assert (dout_exp == exp_exp_q[bin_idx / sc_map_pkg::FFT_SIZE]) else begin
          $display("Error: dout_exp got %h expected %h", dout_exp,
                   exp_exp_q[bin_idx / sc_map_pkg::FFT_SIZE]);
          chk_errs++;
        end
        assert (dout_symbol == exp_sym_q[bin_idx / sc_map_pkg::FFT_SIZE]) else begin
          $display("Error: dout_symbol got %h expected %h", dout_symbol,
                   exp_sym_q[bin_idx / sc_map_pkg::FFT_SIZE]);
          chk_errs++;
        end
      end
      bin_idx++;
      bin_pos = (bin_pos == sc_map_pkg::FFT_SIZE - 1) ? 0 : bin_pos + 1;
    end
  end

  initial begin : watchdog
    while (cycle_cnt < CYCLE_LIMIT) begin
      @(posedge clk_rd);
      cycle_cnt++;
    end
    $display("run stopped after %0d cycles, a test never finished", cycle_cnt);
    $display("Test failed");
    $finish;
  end

  initial begin : main
    int          out_mark;
    int          credit_mark;
    logic [31:0] r;
    void'($urandom(13257));
    clk_rd     = 1'b0;
    rst_n      = 1'b0;
    din_valid  = 1'b0;
    din_sop    = 1'b0;
    din_word   = '0;
    din_exp    = '0;
    din_symbol = '0;
    dc_enable  = 1'b1;
    dout_ready = 1'b1;
    repeat (16) @(posedge clk_rd);
    #1;
    rst_n = 1'b1;

    begin_test();
    dc_enable = 1'b1;
    send_block(0, 0);
    wait_drain();
    report_test("single block, DC bin used");

    begin_test();
    dc_enable = 1'b0;                                      // changed only while idle
    send_block(0, 0);
    wait_drain();
    report_test("single block, DC bin empty");

    begin_test();
    dc_enable = 1'b1;
    repeat (N_MULTI) send_block(30, 0);
    wait_drain();
    report_test("block order and metadata");

    begin_test();
    dc_enable   = 1'b0;
    dout_ready  = 1'b0;
    out_mark    = out_cnt;
    credit_mark = credit_total;
    repeat (sc_map_pkg::BLOCK_QTY) send_block(10, 0);
    while (!bloc_full) idle_cycle();
    repeat (20) idle_cycle();                              // hold, nothing may move
    assert (bloc_used == sc_map_pkg::BLOCK_QTY) else begin
      $display("Error: bloc_used got %h expected %h", bloc_used, sc_map_pkg::BLOCK_QTY);
      seq_errs++;
    end
    assert (out_cnt == out_mark) else begin
      $display("output appeared while dout_ready was low");
      seq_errs++;
    end
    assert (credit_total == credit_mark) else begin
      $display("a credit came back before any symbol was read");
      seq_errs++;
    end
    assert (sc_map_pkg::BLOCK_QTY + credit_total - spent == 0) else begin
      $display("source still holds credits with the buffer full");
      seq_errs++;
    end
    dout_ready = 1'b1;
    wait_drain();
    assert (credit_total - credit_mark == sc_map_pkg::BLOCK_QTY) else begin
      $display("Error: din_credit count got %h expected %h", credit_total - credit_mark,
               sc_map_pkg::BLOCK_QTY);
      seq_errs++;
    end
    report_test("full buffer under back-pressure");

    begin_test();
    dc_enable = 1'b1;
    send_block(20, 5);                                     // 5 words, then restart
    wait_drain();
    report_test("restart inside a block");

    begin_test();
    r         = $urandom;
    dc_enable = r[0];
    fork
      begin
        repeat (N_STREAM) send_block(40, 0);
        stream_done = 1'b1;
      end
      begin
        while (!stream_done) begin
          @(posedge clk_rd);
          #1;
          dout_ready = (int'($urandom_range(99)) < 60);
        end
      end
    join
    dout_ready = 1'b1;
    wait_drain();
    assert (bloc_empty) else begin
      $display("Error: bloc_empty got %h expected %h", bloc_empty, 1'b1);
      seq_errs++;
    end
    assert (spent == credit_total) else begin
      $display("credits not all returned at the end of the stream");
      seq_errs++;
    end
    report_test("long random stream");

    $display("summary: %0d tests, %0d with errors, %0d bins checked, %0d errors",
             test_num, tests_bad, out_cnt, chk_errs + seq_errs);
    if (chk_errs + seq_errs == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
